// ==== hdl/soc_interconnect_cfg.svh ====
// SoC interconnect configuration
`ifndef SOC_INTERCONNECT_CFG_SVH
`define SOC_INTERCONNECT_CFG_SVH

// --------------------
// Port counts
// --------------------

// Core data, uDMA, debug
`define N_MASTERS 3

// Word interleaved L2 banks
`define N_L2_BANKS 2

// --------------------
// Widths
// --------------------

// Word address bits inside one bank
`define ADDR_MEM_WIDTH 8
`define DATA_WIDTH 32
`define BE_WIDTH 4

// --------------------
// Address map
// --------------------

// Banks x 2^ADDR_MEM_WIDTH words x 4 bytes
`define L2_BASE 32'h1C00_0000
`define L2_SIZE 32'h0000_0800

`define APB_BASE 32'h1A10_0000
`define APB_SIZE 32'h0001_0000

`endif

// ==== hdl/soc_interconnect_pkg.sv ====
// SoC interconnect types
`include "soc_interconnect_cfg.svh"

package soc_interconnect_pkg;

    localparam int unsigned MST_IDX_W  = $clog2(`N_MASTERS);
    localparam int unsigned BANK_IDX_W = $clog2(`N_L2_BANKS);

    // Lint request, wen low means write
    typedef struct packed {
        logic                   req;
        logic                   wen;
        logic [31:0]            addr;
        logic [`DATA_WIDTH-1:0] wdata;
        logic [`BE_WIDTH-1:0]   be;
    } lint_req_t;

    typedef struct packed {
        logic                   r_valid;
        logic                   r_opc;
        logic [`DATA_WIDTH-1:0] r_rdata;
    } lint_rsp_t;

    typedef enum logic [1:0] {
        TGT_L2,
        TGT_APB,
        TGT_ERR
    } target_e;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_e;

    typedef struct packed {
        logic [31:0]            paddr;
        logic [`DATA_WIDTH-1:0] pwdata;
        logic                   pwrite;
        logic                   psel;
        logic                   penable;
    } apb_req_t;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

    // First requester at or after ptr
    function automatic logic [MST_IDX_W-1:0] rr_pick(
        input logic [`N_MASTERS-1:0] req,
        input logic [MST_IDX_W-1:0]  ptr
    );
        int unsigned pos;
        logic        found;
        rr_pick = ptr;
        found   = 1'b0;
        for (int k = 0; k < `N_MASTERS; k++)
        begin
            pos = ptr + k;
            if (pos >= `N_MASTERS)
            begin
                pos = pos - `N_MASTERS;
            end
            if (!found && req[pos])
            begin
                rr_pick = MST_IDX_W'(pos);
                found   = 1'b1;
            end
        end
    endfunction

    // Pointer moves one past the last winner
    function automatic logic [MST_IDX_W-1:0] rr_next(input logic [MST_IDX_W-1:0] idx);
        rr_next = (idx == MST_IDX_W'(`N_MASTERS - 1)) ? '0 : idx + 1'b1;
    endfunction

endpackage

// ==== hdl/lint_port_router.sv ====
// Lint master port router
`timescale 1ns/1ns
`include "soc_interconnect_cfg.svh"

module lint_port_router
    import soc_interconnect_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  lint_req_t                     req_i,
    output logic                          gnt_o,
    output lint_rsp_t                     rsp_o,
    output logic      [`N_L2_BANKS:0]     tgt_req_o,
    input  logic      [`N_L2_BANKS:0]     tgt_gnt_i,
    input  lint_rsp_t [`N_L2_BANKS:0]     tgt_rsp_i
);

    target_e               tgt;
    logic [BANK_IDX_W-1:0] bank_idx;
    logic                  err_req;
    logic                  err_q;

    // --------------------
    // Address decode
    // --------------------
    always_comb
    begin
        if (req_i.addr >= `L2_BASE && req_i.addr < `L2_BASE + `L2_SIZE)
        begin
            tgt = TGT_L2;
        end
        else if (req_i.addr >= `APB_BASE && req_i.addr < `APB_BASE + `APB_SIZE)
        begin
            tgt = TGT_APB;
        end
        else
        begin
            tgt = TGT_ERR;
        end
    end

    // Word address modulo bank count, base is aligned
    assign bank_idx = req_i.addr[2 +: BANK_IDX_W];

    always_comb
    begin
        tgt_req_o = '0;
        if (req_i.req)
        begin
            case (tgt)
                TGT_L2:  tgt_req_o[bank_idx] = 1'b1;
                TGT_APB: tgt_req_o[`N_L2_BANKS] = 1'b1;
                default: tgt_req_o = '0;
            endcase
        end
    end

    // Unmapped accesses are granted at once
    assign err_req = req_i.req && (tgt == TGT_ERR);
    assign gnt_o   = (|tgt_gnt_i) || err_req;

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            err_q <= 1'b0;
        end
        else
        begin
            err_q <= err_req;
        end
    end

    // --------------------
    // Response merge
    // --------------------
    always_comb
    begin
        rsp_o = '0;
        for (int t = 0; t <= `N_L2_BANKS; t++)
        begin
            rsp_o = rsp_o | tgt_rsp_i[t];
        end
        if (err_q)
        begin
            rsp_o.r_valid = 1'b1;
            rsp_o.r_opc   = 1'b1;
        end
    end

endmodule

// ==== hdl/l2_bank_arbiter.sv ====
// L2 bank round-robin arbiter
`timescale 1ns/1ns
`include "soc_interconnect_cfg.svh"

module l2_bank_arbiter
    import soc_interconnect_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic      [`N_MASTERS-1:0]    req_i,
    input  lint_req_t [`N_MASTERS-1:0]    payload_i,
    output logic      [`N_MASTERS-1:0]    gnt_o,
    output lint_rsp_t [`N_MASTERS-1:0]    rsp_o,
    output logic                          ram_csn_o,
    output logic                          ram_wen_o,
    output logic [`ADDR_MEM_WIDTH-1:0]    ram_addr_o,
    output logic [`DATA_WIDTH-1:0]        ram_wdata_o,
    output logic [`BE_WIDTH-1:0]          ram_be_o,
    input  logic [`DATA_WIDTH-1:0]        ram_rdata_i
);

    logic [MST_IDX_W-1:0] rr_q;
    logic [MST_IDX_W-1:0] win;
    logic [MST_IDX_W-1:0] win_q;
    logic                 any_req;
    logic                 valid_q;
    lint_req_t            win_req;

    assign any_req = |req_i;
    assign win     = rr_pick(req_i, rr_q);
    assign win_req = payload_i[win];

    always_comb
    begin
        gnt_o = '0;
        if (any_req)
        begin
            gnt_o[win] = 1'b1;
        end
    end

    // Winner drives the bank, bank select bits dropped
    assign ram_csn_o   = ~any_req;
    assign ram_wen_o   = win_req.wen;
    assign ram_addr_o  = win_req.addr[2 + BANK_IDX_W +: `ADDR_MEM_WIDTH];
    assign ram_wdata_o = win_req.wdata;
    assign ram_be_o    = win_req.be;

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            rr_q    <= '0;
            win_q   <= '0;
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= any_req;
            if (any_req)
            begin
                win_q <= win;
                rr_q  <= rr_next(win);
            end
        end
    end

    // Read data lands one cycle after the grant
    always_comb
    begin
        for (int m = 0; m < `N_MASTERS; m++)
        begin
            rsp_o[m] = '0;
            if (valid_q && win_q == MST_IDX_W'(m))
            begin
                rsp_o[m].r_valid = 1'b1;
                rsp_o[m].r_rdata = ram_rdata_i;
            end
        end
    end

endmodule

// ==== hdl/l2_ram.sv ====
// Behavioural L2 bank SRAM
`timescale 1ns/1ns
`include "soc_interconnect_cfg.svh"

module l2_ram (
    input  logic                       clk_i,
    input  logic                       csn_i,
    input  logic                       wen_i,
    input  logic [`ADDR_MEM_WIDTH-1:0] addr_i,
    input  logic [`DATA_WIDTH-1:0]     wdata_i,
    input  logic [`BE_WIDTH-1:0]       be_i,
    output logic [`DATA_WIDTH-1:0]     rdata_o
);

    logic [`DATA_WIDTH-1:0] mem [2**`ADDR_MEM_WIDTH];

    // Active low chip select and write enable
    always_ff @(posedge clk_i)
    begin
        if (!csn_i)
        begin
            if (!wen_i)
            begin
                for (int b = 0; b < `BE_WIDTH; b++)
                begin
                    if (be_i[b])
                    begin
                        mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
            end
            else
            begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

// ==== hdl/lint_to_apb_bridge.sv ====
// Lint to APB bridge
`timescale 1ns/1ns
`include "soc_interconnect_cfg.svh"

module lint_to_apb_bridge
    import soc_interconnect_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic      [`N_MASTERS-1:0]    req_i,
    input  lint_req_t [`N_MASTERS-1:0]    payload_i,
    output logic      [`N_MASTERS-1:0]    gnt_o,
    output lint_rsp_t [`N_MASTERS-1:0]    rsp_o,
    output apb_req_t                      apb_req_o,
    input  apb_rsp_t                      apb_rsp_i
);

    apb_state_e             state_q;
    apb_state_e             state_d;
    logic [MST_IDX_W-1:0]   rr_q;
    logic [MST_IDX_W-1:0]   win;
    logic [MST_IDX_W-1:0]   sel_q;
    logic                   start;
    logic                   done;
    logic [31:0]            paddr_q;
    logic [`DATA_WIDTH-1:0] pwdata_q;
    logic                   pwrite_q;
    logic                   rsp_valid_q;
    logic                   rsp_opc_q;
    logic [`DATA_WIDTH-1:0] rsp_rdata_q;

    assign win   = rr_pick(req_i, rr_q);
    assign start = (state_q == APB_IDLE) && (|req_i);
    assign done  = (state_q == APB_ACCESS) && apb_rsp_i.pready;

    // --------------------
    // APB sequence
    // --------------------
    always_comb
    begin
        case (state_q)
            APB_IDLE:   state_d = start ? APB_SETUP : APB_IDLE;
            APB_SETUP:  state_d = APB_ACCESS;
            APB_ACCESS: state_d = apb_rsp_i.pready ? APB_IDLE : APB_ACCESS;
            default:    state_d = APB_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state_q     <= APB_IDLE;
            rr_q        <= '0;
            sel_q       <= '0;
            rsp_valid_q <= 1'b0;
        end
        else
        begin
            state_q     <= state_d;
            rsp_valid_q <= done;
            if (start)
            begin
                sel_q <= win;
                rr_q  <= rr_next(win);
            end
        end
    end

    // Transfer and read data registers
    always_ff @(posedge clk_i)
    begin
        if (start)
        begin
            paddr_q  <= payload_i[win].addr;
            pwdata_q <= payload_i[win].wdata;
            pwrite_q <= ~payload_i[win].wen;
        end
        if (done)
        begin
            rsp_rdata_q <= apb_rsp_i.prdata;
            rsp_opc_q   <= apb_rsp_i.pslverr;
        end
    end

    assign apb_req_o.paddr   = paddr_q;
    assign apb_req_o.pwdata  = pwdata_q;
    assign apb_req_o.pwrite  = pwrite_q;
    assign apb_req_o.psel    = (state_q != APB_IDLE);
    assign apb_req_o.penable = (state_q == APB_ACCESS);

    // --------------------
    // Lint side
    // --------------------

    // Grant only in the pready cycle
    always_comb
    begin
        gnt_o = '0;
        if (done)
        begin
            gnt_o[sel_q] = 1'b1;
        end
    end

    always_comb
    begin
        for (int m = 0; m < `N_MASTERS; m++)
        begin
            rsp_o[m] = '0;
            if (rsp_valid_q && sel_q == MST_IDX_W'(m))
            begin
                rsp_o[m].r_valid = 1'b1;
                rsp_o[m].r_opc   = rsp_opc_q;
                rsp_o[m].r_rdata = rsp_rdata_q;
            end
        end
    end

endmodule

// ==== hdl/soc_interconnect.sv ====
// SoC data interconnect top
`timescale 1ns/1ns
`include "soc_interconnect_cfg.svh"

module soc_interconnect
    import soc_interconnect_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  lint_req_t [`N_MASTERS-1:0]    master_req_i,
    output logic      [`N_MASTERS-1:0]    master_gnt_o,
    output lint_rsp_t [`N_MASTERS-1:0]    master_rsp_o,
    output apb_req_t                      apb_req_o,
    input  apb_rsp_t                      apb_rsp_i
);

    // Master major, as seen by the routers
    logic      [`N_MASTERS-1:0][`N_L2_BANKS:0]  m_req;
    logic      [`N_MASTERS-1:0][`N_L2_BANKS:0]  m_gnt;
    lint_rsp_t [`N_MASTERS-1:0][`N_L2_BANKS:0]  m_rsp;

    // Target major, as seen by the arbiters
    logic      [`N_L2_BANKS:0][`N_MASTERS-1:0]  t_req;
    logic      [`N_L2_BANKS:0][`N_MASTERS-1:0]  t_gnt;
    lint_rsp_t [`N_L2_BANKS:0][`N_MASTERS-1:0]  t_rsp;

    logic [`N_L2_BANKS-1:0]                      ram_csn;
    logic [`N_L2_BANKS-1:0]                      ram_wen;
    logic [`N_L2_BANKS-1:0][`ADDR_MEM_WIDTH-1:0] ram_addr;
    logic [`N_L2_BANKS-1:0][`DATA_WIDTH-1:0]     ram_wdata;
    logic [`N_L2_BANKS-1:0][`BE_WIDTH-1:0]       ram_be;
    logic [`N_L2_BANKS-1:0][`DATA_WIDTH-1:0]     ram_rdata;

    for (genvar m = 0; m < `N_MASTERS; m++)
    begin : g_master
        lint_port_router i_router (
            .clk_i     ( clk_i           ),
            .rst_n_i   ( rst_n_i         ),
            .req_i     ( master_req_i[m] ),
            .gnt_o     ( master_gnt_o[m] ),
            .rsp_o     ( master_rsp_o[m] ),
            .tgt_req_o ( m_req[m]        ),
            .tgt_gnt_i ( m_gnt[m]        ),
            .tgt_rsp_i ( m_rsp[m]        )
        );

        for (genvar t = 0; t <= `N_L2_BANKS; t++)
        begin : g_xpose
            assign t_req[t][m] = m_req[m][t];
            assign m_gnt[m][t] = t_gnt[t][m];
            assign m_rsp[m][t] = t_rsp[t][m];
        end
    end

    for (genvar b = 0; b < `N_L2_BANKS; b++)
    begin : g_bank
        l2_bank_arbiter i_arbiter (
            .clk_i       ( clk_i        ),
            .rst_n_i     ( rst_n_i      ),
            .req_i       ( t_req[b]     ),
            .payload_i   ( master_req_i ),
            .gnt_o       ( t_gnt[b]     ),
            .rsp_o       ( t_rsp[b]     ),
            .ram_csn_o   ( ram_csn[b]   ),
            .ram_wen_o   ( ram_wen[b]   ),
            .ram_addr_o  ( ram_addr[b]  ),
            .ram_wdata_o ( ram_wdata[b] ),
            .ram_be_o    ( ram_be[b]    ),
            .ram_rdata_i ( ram_rdata[b] )
        );

        l2_ram i_ram (
            .clk_i   ( clk_i        ),
            .csn_i   ( ram_csn[b]   ),
            .wen_i   ( ram_wen[b]   ),
            .addr_i  ( ram_addr[b]  ),
            .wdata_i ( ram_wdata[b] ),
            .be_i    ( ram_be[b]    ),
            .rdata_o ( ram_rdata[b] )
        );
    end

    // Last target slot is the peripheral bus
    lint_to_apb_bridge i_apb_bridge (
        .clk_i     ( clk_i              ),
        .rst_n_i   ( rst_n_i            ),
        .req_i     ( t_req[`N_L2_BANKS] ),
        .payload_i ( master_req_i       ),
        .gnt_o     ( t_gnt[`N_L2_BANKS] ),
        .rsp_o     ( t_rsp[`N_L2_BANKS] ),
        .apb_req_o ( apb_req_o          ),
        .apb_rsp_i ( apb_rsp_i          )
    );

endmodule

// ==== sim/soc_interconnect_assertions.sv ====
// Interconnect protocol assertions
`timescale 1ns/1ns
`include "soc_interconnect_cfg.svh"

module soc_interconnect_assertions
    import soc_interconnect_pkg::*;
(
    input logic                       clk_i,
    input logic                       rst_n_i,
    input lint_req_t [`N_MASTERS-1:0] req_i,
    input logic      [`N_MASTERS-1:0] gnt_i,
    input lint_rsp_t [`N_MASTERS-1:0] rsp_i,
    input apb_req_t                   apb_req_i
);

    for (genvar m = 0; m < `N_MASTERS; m++)
    begin : g_master
        // Payload held until granted
        a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            req_i[m].req && !gnt_i[m] |=> req_i[m].req && $stable(req_i[m]))
        else $error("master %0d changed its request before the grant", m);

        a_rsp_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            gnt_i[m] |=> rsp_i[m].r_valid)
        else $error("master %0d got no response in the cycle after its grant", m);

        a_rsp_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            rsp_i[m].r_valid |-> $past(gnt_i[m]))
        else $error("master %0d got a response without a grant", m);
    end

    // Access phase only after a setup cycle
    a_penable_setup: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        apb_req_i.penable |-> apb_req_i.psel && $past(apb_req_i.psel))
    else $error("penable raised without a preceding psel setup cycle");

endmodule

bind soc_interconnect soc_interconnect_assertions i_assertions (
    .clk_i     ( clk_i        ),
    .rst_n_i   ( rst_n_i      ),
    .req_i     ( master_req_i ),
    .gnt_i     ( master_gnt_o ),
    .rsp_i     ( master_rsp_o ),
    .apb_req_i ( apb_req_o    )
);

// ==== sim/tb_soc_interconnect.sv ====
// SoC interconnect testbench
`timescale 1ns/1ns
`include "soc_interconnect_cfg.svh"

module tb_soc_interconnect
    import soc_interconnect_pkg::*;
();

    localparam int          VEC_FIELDS    = 7;
    localparam int          MAX_VECS      = 64;
    localparam int          GNT_TIMEOUT   = 50;
    localparam int          N_WAITS       = 32;
    localparam int          APB_MAX_WAITS = 2;
    localparam logic [31:0] VEC_END       = 32'hFFFF_FFFF;

    logic                       clk;
    logic                       rst_n;
    lint_req_t [`N_MASTERS-1:0] mreq;
    logic      [`N_MASTERS-1:0] mgnt;
    lint_rsp_t [`N_MASTERS-1:0] mrsp;
    apb_req_t                   apb_req;
    apb_rsp_t                   apb_rsp;

    logic [31:0] vec_mem [VEC_FIELDS*MAX_VECS];
    logic [31:0] apb_regs [16];
    int          apb_waits [N_WAITS];
    int          slot_vec [`N_MASTERS];
    int          slot_bound [`N_MASTERS];
    int          chk_cnt;
    int          err_cnt;

    soc_interconnect UUT (
        .clk_i        ( clk     ),
        .rst_n_i      ( rst_n   ),
        .master_req_i ( mreq    ),
        .master_gnt_o ( mgnt    ),
        .master_rsp_o ( mrsp    ),
        .apb_req_o    ( apb_req ),
        .apb_rsp_i    ( apb_rsp )
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------
    // APB slave model
    // --------------------
    initial
    begin
        int         waits;
        int         txn;
        logic       busy;
        logic [3:0] idx;
        apb_rsp = '0;
        busy    = 1'b0;
        waits   = 0;
        txn     = 0;
        for (int i = 0; i < 16; i++)
        begin
            apb_regs[i] = 32'h5100_0000 | (32'(i) << 12) | 32'(i);
        end
        forever
        begin
            @(posedge clk);
            #1;
            apb_rsp = '0;
            if (rst_n && apb_req.psel && apb_req.penable)
            begin
                if (!busy)
                begin
                    waits = apb_waits[txn % N_WAITS];
                    txn   = txn + 1;
                    busy  = 1'b1;
                end
                if (waits == 0)
                begin
                    idx            = apb_req.paddr[5:2];
                    apb_rsp.pready = 1'b1;
                    busy           = 1'b0;
                    // Last word answers with a slave error
                    if (idx == 4'hF)
                    begin
                        apb_rsp.pslverr = 1'b1;
                    end
                    else if (apb_req.pwrite)
                    begin
                        apb_regs[idx] = apb_req.pwdata;
                    end
                    else
                    begin
                        apb_rsp.prdata = apb_regs[idx];
                    end
                end
                else
                begin
                    waits = waits - 1;
                end
            end
        end
    end

    // --------------------
    // Checks
    // --------------------
    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        chk_cnt++;
        assert (got === exp)
        else
        begin
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_idle();
        for (int m = 0; m < `N_MASTERS; m++)
        begin
            check_eq($sformatf("master_gnt_o[%0d]", m), 32'(mgnt[m]), 32'h0);
            check_eq($sformatf("master_rsp_o[%0d].r_valid", m), 32'(mrsp[m].r_valid), 32'h0);
        end
        check_eq("apb_req_o.psel", 32'(apb_req.psel), 32'h0);
        check_eq("apb_req_o.penable", 32'(apb_req.penable), 32'h0);
    endtask

    function automatic target_e target_kind(input logic [31:0] addr);
        if (addr >= `L2_BASE && addr < `L2_BASE + `L2_SIZE)
        begin
            return TGT_L2;
        end
        if (addr >= `APB_BASE && addr < `APB_BASE + `APB_SIZE)
        begin
            return TGT_APB;
        end
        return TGT_ERR;
    endfunction

    // Word interleaving across banks
    function automatic int bank_of(input logic [31:0] addr);
        return int'((addr >> 2) % `N_L2_BANKS);
    endfunction

    // Grant latency limit for each master of the current group
    task automatic set_bounds();
        logic [31:0] addr_a;
        logic [31:0] addr_b;
        int          n_apb;
        n_apb = 0;
        for (int a = 0; a < `N_MASTERS; a++)
        begin
            if (slot_vec[a] >= 0)
            begin
                addr_a = vec_mem[slot_vec[a] * VEC_FIELDS + 2];
                if (target_kind(addr_a) == TGT_APB)
                begin
                    n_apb++;
                end
            end
        end
        for (int a = 0; a < `N_MASTERS; a++)
        begin
            slot_bound[a] = 0;
            if (slot_vec[a] >= 0)
            begin
                addr_a = vec_mem[slot_vec[a] * VEC_FIELDS + 2];
                if (target_kind(addr_a) == TGT_APB)
                begin
                    // Request, setup and access cycles plus wait states per transfer
                    slot_bound[a] = n_apb * (3 + APB_MAX_WAITS) - 1;
                end
                else if (target_kind(addr_a) == TGT_L2)
                begin
                    for (int b = 0; b < `N_MASTERS; b++)
                    begin
                        if (b != a && slot_vec[b] >= 0)
                        begin
                            addr_b = vec_mem[slot_vec[b] * VEC_FIELDS + 2];
                            if (target_kind(addr_b) == TGT_L2 && bank_of(addr_b) == bank_of(addr_a))
                            begin
                                slot_bound[a]++;
                            end
                        end
                    end
                end
            end
        end
    endtask

    // One lint transaction on master port m
    task automatic run_slot(input int m);
        int          base;
        int          wait_cyc;
        logic        got_gnt;
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] exp_rdata;
        logic [31:0] exp_opc;
        if (slot_vec[m] < 0)
        begin
            return;
        end
        base      = slot_vec[m] * VEC_FIELDS;
        op        = vec_mem[base + 1];
        addr      = vec_mem[base + 2];
        exp_rdata = vec_mem[base + 5];
        exp_opc   = vec_mem[base + 6];

        @(posedge clk);
        #1;
        mreq[m].req   = 1'b1;
        mreq[m].wen   = (op == 32'h0);
        mreq[m].addr  = addr;
        mreq[m].wdata = vec_mem[base + 3];
        mreq[m].be    = vec_mem[base + 4][`BE_WIDTH-1:0];

        wait_cyc = 0;
        got_gnt  = 1'b0;
        while (!got_gnt && wait_cyc < GNT_TIMEOUT)
        begin
            @(negedge clk);
            if (mgnt[m])
            begin
                got_gnt = 1'b1;
            end
            else
            begin
                wait_cyc++;
            end
        end
        @(posedge clk);
        #1;
        mreq[m] = '0;

        if (!got_gnt)
        begin
            $display("master %0d got no grant within %0d cycles for address 0x%08h",
                     m, GNT_TIMEOUT, addr);
            err_cnt++;
            return;
        end
        chk_cnt++;
        assert (wait_cyc <= slot_bound[m])
        else
        begin
            $display("master %0d waited %0d cycles for a grant, more than the %0d allowed",
                     m, wait_cyc, slot_bound[m]);
            err_cnt++;
        end

        // Response lands one cycle after the grant
        @(negedge clk);
        check_eq($sformatf("master_rsp_o[%0d].r_valid", m), 32'(mrsp[m].r_valid), 32'h1);
        check_eq($sformatf("master_rsp_o[%0d].r_opc", m), 32'(mrsp[m].r_opc), exp_opc);
        if (op == 32'h0)
        begin
            check_eq($sformatf("master_rsp_o[%0d].r_rdata", m), mrsp[m].r_rdata, exp_rdata);
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial
    begin
        int   v;
        int   m;
        int   n_vecs;
        int   gap;
        logic group_open;
        void'($urandom(32'ha56ef2bf));
        rst_n   = 1'b0;
        mreq    = '0;
        chk_cnt = 0;
        err_cnt = 0;
        for (int i = 0; i < N_WAITS; i++)
        begin
            apb_waits[i] = int'($urandom % (APB_MAX_WAITS + 1));
        end
        for (int i = 0; i < VEC_FIELDS * MAX_VECS; i++)
        begin
            vec_mem[i] = VEC_END;
        end
        $readmemh("sim/soc_interconnect_vectors.txt", vec_mem);

        repeat (16)
        begin
            @(posedge clk);
        end
        #1;
        rst_n = 1'b1;

        // Quiet ports until the first request
        repeat (3)
        begin
            @(negedge clk);
            check_idle();
        end

        n_vecs = 0;
        while (n_vecs < MAX_VECS && vec_mem[n_vecs * VEC_FIELDS] != VEC_END)
        begin
            n_vecs++;
        end
        chk_cnt++;
        assert (n_vecs > 0)
        else
        begin
            $display("no vectors were read from sim/soc_interconnect_vectors.txt");
            err_cnt++;
        end

        // Requests of one group start in the same cycle
        v = 0;
        while (v < n_vecs)
        begin
            for (int k = 0; k < `N_MASTERS; k++)
            begin
                slot_vec[k] = -1;
            end
            group_open = 1'b1;
            while (group_open && v < n_vecs)
            begin
                m = int'(vec_mem[v * VEC_FIELDS]);
                if (vec_mem[v * VEC_FIELDS + 1] == 32'h2)
                begin
                    group_open = 1'b0;
                    v++;
                end
                else if (m < 0 || m >= `N_MASTERS)
                begin
                    $display("vector %0d names master %0d, which does not exist", v, m);
                    err_cnt++;
                    v++;
                end
                else if (slot_vec[m] >= 0)
                begin
                    group_open = 1'b0;
                end
                else
                begin
                    slot_vec[m] = v;
                    v++;
                end
            end
            set_bounds();
            gap = int'($urandom % 3);
            repeat (gap)
            begin
                @(posedge clk);
            end
            fork
                run_slot(0);
                run_slot(1);
                run_slot(2);
            join
        end

        $display("checks run: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/soc_interconnect_vectors.txt ====
// master op addr wdata be exp_rdata exp_opc, all hex
// op 0 reads, 1 writes, 2 closes a group of requests issued together
0 1 1C000010 11223344 F 00000000 0
1 1 1C000014 55667788 F 00000000 0
0 2 00000000 00000000 0 00000000 0
0 1 1C000010 AABBCCDD 5 00000000 0
2 1 1C000014 99000000 8 00000000 0
0 2 00000000 00000000 0 00000000 0
1 0 1C000010 00000000 0 11BB33DD 0
2 0 1C000010 00000000 0 11BB33DD 0
0 0 1C000014 00000000 0 99667788 0
0 2 00000000 00000000 0 00000000 0
0 1 1A100008 CAFEF00D F 00000000 0
1 1 1A100004 12345678 F 00000000 0
0 2 00000000 00000000 0 00000000 0
2 0 1A100008 00000000 0 CAFEF00D 0
0 0 1A100004 00000000 0 12345678 0
1 0 1A10003C 00000000 0 00000000 1
0 2 00000000 00000000 0 00000000 0
2 0 30000000 00000000 0 00000000 1
0 1 00000100 DEADBEEF F 00000000 1
1 1 1A10003C 0BADF00D F 00000000 1

// ==== sources.f ====
+incdir+hdl
hdl/soc_interconnect_pkg.sv
hdl/lint_port_router.sv
hdl/l2_bank_arbiter.sv
hdl/l2_ram.sv
hdl/lint_to_apb_bridge.sv
hdl/soc_interconnect.sv
sim/soc_interconnect_assertions.sv
sim/tb_soc_interconnect.sv

// ==== Makefile ====
TOP := tb_soc_interconnect

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns -f sources.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
